// File: test/fdtd_mem_ctrl_vectors.txt
// columns: hy_base ez_base size int_en, hex, one job per line
// a size of zero ends the list
0010 0040 0005 1
0020 0060 0008 0
0080 00c0 0013 1
0000 00a0 0001 1
0030 00e0 000b 0
0068 00b0 0010 1

// File: fdtd_mem_ctrl.f
+incdir+include
hw/fdtd_pkg.sv
hw/fdtd_seq_fsm.sv
hw/fdtd_word_counter.sv
hw/fdtd_addr_gen.sv
hw/fdtd_mem_port.sv
hw/fdtd_mem_ctrl.sv
test/fdtd_mem_ctrl_properties.sv
test/fdtd_mem_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module fdtd_mem_ctrl_tb \
    -f fdtd_mem_ctrl.f -o fdtd_mem_ctrl_sim

./obj_dir/fdtd_mem_ctrl_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: test/fdtd_mem_ctrl_tb.sv
module fdtd_mem_ctrl_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_HALF        = 20;
    localparam int          MEM_AW          = 8;
    localparam int          MEM_WORDS       = 1 << MEM_AW;
    localparam int          MAX_TESTS       = 16;
    localparam int          CYCLES_PER_WORD = 40;
    localparam int          MARGIN_CYCLES   = 400;
    localparam logic [31:0] EZ_PATTERN      = 32'h5a5a_0ff0;

    logic                        ACLK;
    logic                        ARESETn;
    logic                        start_i;
    fdtd_pkg::job_cfg_t          cfg_i;
    logic                        int_en_i;
    logic                        clr_int_i;
    logic                        busy_o;
    logic                        int_pending_o;
    logic                        int_o;
    fdtd_pkg::mem_req_t          rd_req_o;
    logic                        rd_req_ready_i;
    logic                        rd_rsp_valid_i;
    logic [fdtd_pkg::DATA_W-1:0] rd_rsp_data_i;
    logic                        rd_rsp_ready_o;
    fdtd_pkg::mem_wr_t           wr_o;
    logic                        wr_ready_i;
    fdtd_pkg::fld_word_t         buf_out_o;
    logic                        buf_out_ready_i;
    fdtd_pkg::fld_word_t         buf_in_i;
    logic                        buf_in_ready_o;

    integer              seed = 32'hed41;
    int                  err_count;
    int                  tests_run;
    int                  tests_failed;
    int                  cycle_count;
    int                  cycle_limit;
    logic [31:0]         mem  [MEM_WORDS];
    logic [31:0]         orig [MEM_WORDS];
    logic [31:0]         vec  [4*MAX_TESTS];
    logic [31:0]         rd_q [$];
    fdtd_pkg::fld_word_t ret_q [$];
    int                  job_hy;
    int                  job_ez;
    int                  job_size;
    int                  rx_done;
    int                  rx_idx;
    int                  rx_count;
    logic                req_seen;
    logic                rsp_seen;
    logic                out_seen;
    logic                in_seen;

    fdtd_mem_ctrl DUT (.*);

    always #CLK_HALF ACLK = ~ACLK;

    always @(posedge ACLK)
    begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
        begin
            $display("timeout: the run took more than %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic random_ready();
        random_ready = ($random(seed) & 3) != 0;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before)
            $display("%s: ok", name);
        else
        begin
            tests_failed++;
            $display("%s: FAILED", name);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory and compute buffer models
    //////////////////////////////////////////////////////////////////////

    // expected beat from the block rule, then the computed word goes back
    task automatic take_buffer_word(input fdtd_pkg::fld_word_t beat);
        int                  blen;
        int                  addr;
        fdtd_pkg::field_e    exp_field;
        fdtd_pkg::fld_word_t ret;
        blen = job_size - rx_done;
        if (blen > fdtd_pkg::BLOCK_WORDS)
            blen = fdtd_pkg::BLOCK_WORDS;
        if (rx_idx < blen)
        begin
            exp_field = fdtd_pkg::FLD_HY;
            addr      = job_hy + rx_done + rx_idx;
        end
        else
        begin
            exp_field = fdtd_pkg::FLD_EZ;
            addr      = job_ez + rx_done + rx_idx - blen;
        end
        check_eq(beat.field, exp_field, $sformatf("field of buffer word %0d", rx_count));
        check_eq(beat.data, orig[addr % MEM_WORDS],
                 $sformatf("data of buffer word %0d", rx_count));
        ret      = beat;
        ret.data = (beat.field == fdtd_pkg::FLD_HY) ? beat.data + 1 : beat.data ^ EZ_PATTERN;
        ret_q.push_back(ret);
        rx_count++;
        rx_idx++;
        if (rx_idx >= 2 * blen)
        begin
            rx_done += blen;
            rx_idx   = 0;
        end
    endtask

    // handshakes sampled mid cycle, where all signals are settled
    always @(negedge ACLK)
    begin
        req_seen = rd_req_o.valid && rd_req_ready_i;
        rsp_seen = rd_rsp_valid_i && rd_rsp_ready_o;
        out_seen = buf_out_o.valid && buf_out_ready_i;
        in_seen  = buf_in_i.valid && buf_in_ready_o;
        if (req_seen)
        begin
            if (rd_req_o.addr < MEM_WORDS)
                rd_q.push_back(mem[rd_req_o.addr[MEM_AW-1:0]]);
            else
            begin
                $display("read request to address %h is outside the memory model", rd_req_o.addr);
                err_count++;
            end
        end
        if (wr_o.valid && wr_ready_i)
        begin
            if (wr_o.addr < MEM_WORDS)
                mem[wr_o.addr[MEM_AW-1:0]] = wr_o.data;
            else
            begin
                $display("write to address %h is outside the memory model", wr_o.addr);
                err_count++;
            end
        end
        if (out_seen)
            take_buffer_word(buf_out_o);
    end

    always @(posedge ACLK)
    begin
        #1;
        rd_req_ready_i  = random_ready();
        buf_out_ready_i = random_ready();
        wr_ready_i      = random_ready();
        if (rsp_seen)
            rd_rsp_valid_i = 1'b0;
        // responses in request order, with random gaps
        if (!rd_rsp_valid_i && rd_q.size() > 0 && random_ready())
        begin
            rd_rsp_data_i  = rd_q.pop_front();
            rd_rsp_valid_i = 1'b1;
        end
        if (in_seen)
            buf_in_i.valid = 1'b0;
        if (!buf_in_i.valid && ret_q.size() > 0 && random_ready())
            buf_in_i = ret_q.pop_front();
    end

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        int errs_before;
        errs_before = err_count;
        @(negedge ACLK);
        check_eq(busy_o, 1'b0, "busy_o after reset");
        check_eq(int_pending_o, 1'b0, "int_pending_o after reset");
        check_eq(int_o, 1'b0, "int_o after reset");
        check_eq(rd_req_o.valid, 1'b0, "read request valid after reset");
        check_eq(wr_o.valid, 1'b0, "write valid after reset");
        check_eq(buf_out_o.valid, 1'b0, "buffer out valid after reset");
        report_test("reset state", errs_before);
    endtask

    task automatic run_job(input int t);
        int          errs_before;
        logic [31:0] exp;
        errs_before = err_count;
        job_hy      = vec[4*t];
        job_ez      = vec[4*t+1];
        job_size    = vec[4*t+2];
        rx_done     = 0;
        rx_idx      = 0;
        rx_count    = 0;
        for (int a = 0; a < MEM_WORDS; a++)
            orig[a] = mem[a];
        @(posedge ACLK);
        #1;
        cfg_i.hy_base = job_hy;
        cfg_i.ez_base = job_ez;
        cfg_i.size    = job_size[fdtd_pkg::SIZE_W-1:0];
        int_en_i      = vec[4*t+3][0];
        start_i       = 1'b1;
        @(posedge ACLK);
        #1;
        start_i = 1'b0;
        @(negedge ACLK);
        check_eq(busy_o, 1'b1, "busy_o after start");
        while (busy_o)
            @(negedge ACLK);
        check_eq(int_pending_o, 1'b0, "int_pending_o as busy_o falls");
        // pending follows one cycle after the falling edge of busy
        @(negedge ACLK);
        check_eq(int_pending_o, 1'b1, "int_pending_o after the job");
        check_eq(int_o, int_en_i, "int_o with a pending interrupt");
        check_eq(rx_count, 2 * job_size, "words sent to the buffer");
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            exp = orig[a];
            if (a >= job_hy && a < job_hy + job_size)
                exp = orig[a] + 1;
            if (a >= job_ez && a < job_ez + job_size)
                exp = orig[a] ^ EZ_PATTERN;
            check_eq(mem[a], exp, $sformatf("memory word %0h", a));
        end
        @(posedge ACLK);
        #1;
        clr_int_i = 1'b1;
        @(posedge ACLK);
        #1;
        clr_int_i = 1'b0;
        @(negedge ACLK);
        check_eq(int_pending_o, 1'b0, "int_pending_o after clear");
        check_eq(int_o, 1'b0, "int_o after clear");
        report_test($sformatf("job %0d, %0d words, int_en %0d", t, job_size, int_en_i),
                    errs_before);
    endtask

    initial
    begin
        int n_tests;
        int total_words;
        ACLK            = 1'b0;
        ARESETn         = 1'b0;
        start_i         = 1'b0;
        cfg_i           = '0;
        int_en_i        = 1'b0;
        clr_int_i       = 1'b0;
        rd_req_ready_i  = 1'b0;
        rd_rsp_valid_i  = 1'b0;
        rd_rsp_data_i   = '0;
        wr_ready_i      = 1'b0;
        buf_out_ready_i = 1'b0;
        buf_in_i        = '0;
        req_seen        = 1'b0;
        rsp_seen        = 1'b0;
        out_seen        = 1'b0;
        in_seen         = 1'b0;
        err_count       = 0;
        tests_run       = 0;
        tests_failed    = 0;
        cycle_count     = 0;
        cycle_limit     = 0;
        for (int i = 0; i < 4 * MAX_TESTS; i++)
            vec[i] = '0;
        $readmemh("test/fdtd_mem_ctrl_vectors.txt", vec);
        n_tests     = 0;
        total_words = 0;
        while (n_tests < MAX_TESTS && vec[4*n_tests+2] != 0)
        begin
            total_words += vec[4*n_tests+2];
            n_tests++;
        end
        if (n_tests == 0)
        begin
            $display("no test vectors were read");
            err_count++;
        end
        cycle_limit = CYCLES_PER_WORD * total_words + MARGIN_CYCLES;
        for (int a = 0; a < MEM_WORDS; a++)
            mem[a] = $random(seed);
        repeat (3) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;
        check_reset_state();
        for (int t = 0; t < n_tests; t++)
            run_job(t);
        $display("%0d tests, %0d failed, %0d failed checks, %0d assertion failures",
                 tests_run, tests_failed, err_count, DUT.u_props.fail_count);
        if (err_count == 0 && DUT.u_props.fail_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: test/fdtd_mem_ctrl_properties.sv
module fdtd_mem_ctrl_properties
(
    input  logic                        ACLK,
    input  logic                        ARESETn,
    input  logic                        start_i,
    input  fdtd_pkg::field_e            wr_field_i,
    input  logic                        busy_o,
    input  fdtd_pkg::mem_req_t          rd_req_o,
    input  logic                        rd_req_ready_i,
    input  logic                        rd_rsp_valid_i,
    input  logic [fdtd_pkg::DATA_W-1:0] rd_rsp_data_i,
    input  logic                        rd_rsp_ready_o,
    input  fdtd_pkg::mem_wr_t           wr_o,
    input  logic                        wr_ready_i,
    input  fdtd_pkg::fld_word_t         buf_out_o,
    input  logic                        buf_out_ready_i,
    input  fdtd_pkg::fld_word_t         buf_in_i,
    input  logic                        buf_in_ready_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // read by the testbench at the end of the run
    int fail_count = 0;

    logic out_fire;
    logic wr_fire;
    int   in_flight;
    logic write_back;

    assign out_fire = buf_out_o.valid && buf_out_ready_i;
    assign wr_fire  = wr_o.valid && wr_ready_i;

    // buffer words of the block not yet written back to memory
    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            in_flight  <= 0;
            write_back <= 1'b0;
        end
        else
        begin
            in_flight <= in_flight + int'(out_fire) - int'(wr_fire);
            // write-back lasts from its first word until the block is drained
            if (wr_fire)
                write_back <= (in_flight > 1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stalled beats keep valid and payload
    //////////////////////////////////////////////////////////////////////

    req_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        rd_req_o.valid && !rd_req_ready_i |=> rd_req_o.valid && $stable(rd_req_o))
    else
    begin
        $error("read request changed while stalled");
        fail_count++;
    end

    rsp_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        rd_rsp_valid_i && !rd_rsp_ready_o |=> rd_rsp_valid_i && $stable(rd_rsp_data_i))
    else
    begin
        $error("read response changed while stalled");
        fail_count++;
    end

    wr_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        wr_o.valid && !wr_ready_i |=> wr_o.valid && $stable(wr_o))
    else
    begin
        $error("write changed while stalled");
        fail_count++;
    end

    buf_out_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        buf_out_o.valid && !buf_out_ready_i |=> buf_out_o.valid && $stable(buf_out_o))
    else
    begin
        $error("buffer out beat changed while stalled");
        fail_count++;
    end

    buf_in_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        buf_in_i.valid && !buf_in_ready_o |=> buf_in_i.valid && $stable(buf_in_i))
    else
    begin
        $error("buffer in beat changed while stalled");
        fail_count++;
    end

    //////////////////////////////////////////////////////////////////////
    // phase and field rules
    //////////////////////////////////////////////////////////////////////

    // no request while idle or while a block is written back
    req_in_read: assert property (@(posedge ACLK) disable iff (!ARESETn)
        !busy_o || write_back |-> !rd_req_o.valid)
    else
    begin
        $error("read request outside the read phase");
        fail_count++;
    end

    // a wrong tag here is a fault of the buffer model
    buf_in_field: assert property (@(posedge ACLK) disable iff (!ARESETn)
        buf_in_i.valid && buf_in_ready_o |-> buf_in_i.field == wr_field_i)
    else
    begin
        $error("buffer in field differs from the expected field");
        fail_count++;
    end

    idle_until_start: assert property (@(posedge ACLK) disable iff (!ARESETn)
        !busy_o && !start_i |=> !busy_o)
    else
    begin
        $error("busy_o rose without a start");
        fail_count++;
    end

endmodule

bind fdtd_mem_ctrl fdtd_mem_ctrl_properties u_props
(
    .ACLK            ( ACLK            ),
    .ARESETn         ( ARESETn         ),
    .start_i         ( start_i         ),
    .wr_field_i      ( wr_field        ),
    .busy_o          ( busy_o          ),
    .rd_req_o        ( rd_req_o        ),
    .rd_req_ready_i  ( rd_req_ready_i  ),
    .rd_rsp_valid_i  ( rd_rsp_valid_i  ),
    .rd_rsp_data_i   ( rd_rsp_data_i   ),
    .rd_rsp_ready_o  ( rd_rsp_ready_o  ),
    .wr_o            ( wr_o            ),
    .wr_ready_i      ( wr_ready_i      ),
    .buf_out_o       ( buf_out_o       ),
    .buf_out_ready_i ( buf_out_ready_i ),
    .buf_in_i        ( buf_in_i        ),
    .buf_in_ready_o  ( buf_in_ready_o  )
);

// File: hw/fdtd_mem_ctrl.sv
module fdtd_mem_ctrl
(
    input  logic                        ACLK,
    input  logic                        ARESETn,

    input  logic                        start_i,
    input  fdtd_pkg::job_cfg_t          cfg_i,
    input  logic                        int_en_i,
    input  logic                        clr_int_i,
    output logic                        busy_o,
    output logic                        int_pending_o,
    output logic                        int_o,

    output fdtd_pkg::mem_req_t          rd_req_o,
    input  logic                        rd_req_ready_i,
    input  logic                        rd_rsp_valid_i,
    input  logic [fdtd_pkg::DATA_W-1:0] rd_rsp_data_i,
    output logic                        rd_rsp_ready_o,
    output fdtd_pkg::mem_wr_t           wr_o,
    input  logic                        wr_ready_i,

    output fdtd_pkg::fld_word_t         buf_out_o,
    input  logic                        buf_out_ready_i,
    input  fdtd_pkg::fld_word_t         buf_in_i,
    output logic                        buf_in_ready_o
);

    fdtd_pkg::phase_e            phase;
    fdtd_pkg::field_e            req_field;
    fdtd_pkg::field_e            rsp_field;
    fdtd_pkg::field_e            wr_field;
    logic                        load;
    logic                        read_done;
    logic                        write_done;
    logic                        job_done;
    logic                        req_stop;
    logic                        req_fire;
    logic                        rsp_fire;
    logic                        wr_fire;
    logic [fdtd_pkg::ADDR_W-1:0] rd_addr;
    logic [fdtd_pkg::ADDR_W-1:0] wr_addr;

    fdtd_seq_fsm u_fsm
    (
        .ACLK          ( ACLK          ),
        .ARESETn       ( ARESETn       ),
        .start_i       ( start_i       ),
        .int_en_i      ( int_en_i      ),
        .clr_int_i     ( clr_int_i     ),
        .read_done_i   ( read_done     ),
        .write_done_i  ( write_done    ),
        .job_done_i    ( job_done      ),
        .phase_o       ( phase         ),
        .load_o        ( load          ),
        .busy_o        ( busy_o        ),
        .int_pending_o ( int_pending_o ),
        .int_o         ( int_o         )
    );

    fdtd_word_counter u_cnt
    (
        .ACLK         ( ACLK        ),
        .ARESETn      ( ARESETn     ),
        .phase_i      ( phase       ),
        .load_i       ( load        ),
        .size_i       ( cfg_i.size  ),
        .req_fire_i   ( req_fire    ),
        .rsp_fire_i   ( rsp_fire    ),
        .wr_fire_i    ( wr_fire     ),
        .req_field_o  ( req_field   ),
        .rsp_field_o  ( rsp_field   ),
        .wr_field_o   ( wr_field    ),
        .req_stop_o   ( req_stop    ),
        .read_done_o  ( read_done   ),
        .write_done_o ( write_done  ),
        .job_done_o   ( job_done    )
    );

    fdtd_addr_gen u_addr
    (
        .ACLK        ( ACLK      ),
        .ARESETn     ( ARESETn   ),
        .load_i      ( load      ),
        .cfg_i       ( cfg_i     ),
        .req_fire_i  ( req_fire  ),
        .req_field_i ( req_field ),
        .wr_fire_i   ( wr_fire   ),
        .wr_field_i  ( wr_field  ),
        .rd_addr_o   ( rd_addr   ),
        .wr_addr_o   ( wr_addr   )
    );

    fdtd_mem_port u_port
    (
        .phase_i         ( phase           ),
        .rsp_field_i     ( rsp_field       ),
        .req_stop_i      ( req_stop        ),
        .rd_addr_i       ( rd_addr         ),
        .wr_addr_i       ( wr_addr         ),
        .rd_req_o        ( rd_req_o        ),
        .rd_req_ready_i  ( rd_req_ready_i  ),
        .rd_rsp_valid_i  ( rd_rsp_valid_i  ),
        .rd_rsp_data_i   ( rd_rsp_data_i   ),
        .rd_rsp_ready_o  ( rd_rsp_ready_o  ),
        .wr_o            ( wr_o            ),
        .wr_ready_i      ( wr_ready_i      ),
        .buf_out_o       ( buf_out_o       ),
        .buf_out_ready_i ( buf_out_ready_i ),
        .buf_in_i        ( buf_in_i        ),
        .buf_in_ready_o  ( buf_in_ready_o  ),
        .req_fire_o      ( req_fire        ),
        .rsp_fire_o      ( rsp_fire        ),
        .wr_fire_o       ( wr_fire         )
    );

endmodule

// File: hw/fdtd_mem_port.sv
module fdtd_mem_port
(
    input  fdtd_pkg::phase_e            phase_i,
    input  fdtd_pkg::field_e            rsp_field_i,
    input  logic                        req_stop_i,
    input  logic [fdtd_pkg::ADDR_W-1:0] rd_addr_i,
    input  logic [fdtd_pkg::ADDR_W-1:0] wr_addr_i,

    // memory side
    output fdtd_pkg::mem_req_t          rd_req_o,
    input  logic                        rd_req_ready_i,
    input  logic                        rd_rsp_valid_i,
    input  logic [fdtd_pkg::DATA_W-1:0] rd_rsp_data_i,
    output logic                        rd_rsp_ready_o,
    output fdtd_pkg::mem_wr_t           wr_o,
    input  logic                        wr_ready_i,

    // compute buffer side
    output fdtd_pkg::fld_word_t         buf_out_o,
    input  logic                        buf_out_ready_i,
    input  fdtd_pkg::fld_word_t         buf_in_i,
    output logic                        buf_in_ready_o,

    output logic                        req_fire_o,
    output logic                        rsp_fire_o,
    output logic                        wr_fire_o
);

    logic rd_phase;
    logic wr_phase;

    assign rd_phase = (phase_i == fdtd_pkg::PH_READ);
    assign wr_phase = (phase_i == fdtd_pkg::PH_WRITE);

    //////////////////////////////////////////////////////////////////////
    // read side, memory to buffer
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        rd_req_o.valid  = rd_phase && !req_stop_i;
        rd_req_o.addr   = rd_addr_i;

        // response waits in memory while the buffer is stalled
        buf_out_o.valid = rd_phase && rd_rsp_valid_i;
        buf_out_o.field = rsp_field_i;
        buf_out_o.data  = rd_rsp_data_i;
        rd_rsp_ready_o  = rd_phase && buf_out_ready_i;
    end

    assign req_fire_o = rd_req_o.valid && rd_req_ready_i;
    assign rsp_fire_o = buf_out_o.valid && buf_out_ready_i;

    //////////////////////////////////////////////////////////////////////
    // write side, buffer to memory
    //////////////////////////////////////////////////////////////////////

    // the beat lands at the expected field whatever its tag says
    always_comb
    begin
        wr_o.valid     = wr_phase && buf_in_i.valid;
        wr_o.addr      = wr_addr_i;
        wr_o.data      = buf_in_i.data;
        buf_in_ready_o = wr_phase && wr_ready_i;
    end

    assign wr_fire_o = wr_o.valid && wr_ready_i;

endmodule

// File: hw/fdtd_addr_gen.sv
module fdtd_addr_gen
(
    input  logic                        ACLK,
    input  logic                        ARESETn,

    input  logic                        load_i,
    input  fdtd_pkg::job_cfg_t          cfg_i,

    input  logic                        req_fire_i,
    input  fdtd_pkg::field_e            req_field_i,
    input  logic                        wr_fire_i,
    input  fdtd_pkg::field_e            wr_field_i,

    output logic [fdtd_pkg::ADDR_W-1:0] rd_addr_o,
    output logic [fdtd_pkg::ADDR_W-1:0] wr_addr_o
);

    // word pointers indexed by field, Hy at 0 and Ez at 1
    logic [fdtd_pkg::ADDR_W-1:0] rd_ptr [2];
    logic [fdtd_pkg::ADDR_W-1:0] wr_ptr [2];

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            rd_ptr[0] <= '0;
            rd_ptr[1] <= '0;
            wr_ptr[0] <= '0;
            wr_ptr[1] <= '0;
        end
        else if (load_i)
        begin
            // read and write ranges start at the same base
            rd_ptr[0] <= cfg_i.hy_base;
            rd_ptr[1] <= cfg_i.ez_base;
            wr_ptr[0] <= cfg_i.hy_base;
            wr_ptr[1] <= cfg_i.ez_base;
        end
        else
        begin
            if (req_fire_i)
                rd_ptr[req_field_i] <= rd_ptr[req_field_i] + 1'b1;
            if (wr_fire_i)
                wr_ptr[wr_field_i] <= wr_ptr[wr_field_i] + 1'b1;
        end
    end

    assign rd_addr_o = rd_ptr[req_field_i];
    assign wr_addr_o = wr_ptr[wr_field_i];

endmodule

// File: hw/fdtd_word_counter.sv
module fdtd_word_counter
(
    input  logic                        ACLK,
    input  logic                        ARESETn,

    input  fdtd_pkg::phase_e            phase_i,
    input  logic                        load_i,
    input  logic [fdtd_pkg::SIZE_W-1:0] size_i,

    input  logic                        req_fire_i,
    input  logic                        rsp_fire_i,
    input  logic                        wr_fire_i,

    output fdtd_pkg::field_e            req_field_o,
    output fdtd_pkg::field_e            rsp_field_o,
    output fdtd_pkg::field_e            wr_field_o,
    output logic                        req_stop_o,

    output logic                        read_done_o,
    output logic                        write_done_o,
    output logic                        job_done_o
);

    // index 0 requests, 1 responses, 2 written words
    logic [fdtd_pkg::BLK_CNT_W-1:0] cnt [3];
    logic [2:0]                     fire;
    logic [fdtd_pkg::SIZE_W-1:0]    remaining;
    logic [fdtd_pkg::SIZE_W-1:0]    blk_len_full;
    logic [fdtd_pkg::BLK_CNT_W-1:0] blk_len;
    logic [fdtd_pkg::BLK_CNT_W-1:0] blk_total;
    logic [fdtd_pkg::BLK_CNT_W-1:0] blk_max;
    logic [fdtd_pkg::BLK_CNT_W-1:0] outstanding;
    logic                           blk_end;

    assign fire = {wr_fire_i, rsp_fire_i, req_fire_i};

    // last block may be short
    assign blk_len_full = (remaining < fdtd_pkg::BLOCK_LEN) ? remaining : fdtd_pkg::BLOCK_LEN;
    assign blk_len      = blk_len_full[fdtd_pkg::BLK_CNT_W-1:0];
    assign blk_total    = blk_len << 1;
    assign blk_max      = fdtd_pkg::BLOCK_LEN[fdtd_pkg::BLK_CNT_W-1:0];
    assign blk_end      = (phase_i == fdtd_pkg::PH_WRITE) && write_done_o;

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            for (int i = 0; i < 3; i++)
            begin
                cnt[i] <= '0;
            end
        end
        else if (load_i || blk_end)
        begin
            for (int i = 0; i < 3; i++)
            begin
                cnt[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < 3; i++)
            begin
                if (fire[i])
                    cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
            remaining <= '0;
        else if (load_i)
            remaining <= size_i;
        else if (blk_end)
            remaining <= remaining - blk_len_full;
    end

    // Hy first, Ez once the count passes the block length
    assign req_field_o = (cnt[0] < blk_len) ? fdtd_pkg::FLD_HY : fdtd_pkg::FLD_EZ;
    assign rsp_field_o = (cnt[1] < blk_len) ? fdtd_pkg::FLD_HY : fdtd_pkg::FLD_EZ;
    assign wr_field_o  = (cnt[2] < blk_len) ? fdtd_pkg::FLD_HY : fdtd_pkg::FLD_EZ;

    // buffer can hold at most one block of unanswered requests
    assign outstanding = cnt[0] - cnt[1];
    assign req_stop_o  = (cnt[0] == blk_total) || (outstanding >= blk_max);

    assign read_done_o  = (cnt[1] == blk_total);
    assign write_done_o = (cnt[2] == blk_total);
    assign job_done_o   = (remaining <= fdtd_pkg::BLOCK_LEN);

endmodule

// File: hw/fdtd_seq_fsm.sv
module fdtd_seq_fsm
(
    input  logic             ACLK,
    input  logic             ARESETn,

    input  logic             start_i,
    input  logic             int_en_i,
    input  logic             clr_int_i,

    input  logic             read_done_i,
    input  logic             write_done_i,
    input  logic             job_done_i,

    output fdtd_pkg::phase_e phase_o,
    output logic             load_o,
    output logic             busy_o,
    output logic             int_pending_o,
    output logic             int_o
);

    fdtd_pkg::phase_e phase_q;
    fdtd_pkg::phase_e phase_d;
    logic             busy_q;

    //////////////////////////////////////////////////////////////////////
    // phase sequencing
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        phase_d = phase_q;
        case (phase_q)
            fdtd_pkg::PH_IDLE:
            begin
                if (start_i)
                    phase_d = fdtd_pkg::PH_READ;
            end
            fdtd_pkg::PH_READ:
            begin
                if (read_done_i)
                    phase_d = fdtd_pkg::PH_WRITE;
            end
            fdtd_pkg::PH_WRITE:
            begin
                // another block unless this was the last one
                if (write_done_i)
                    phase_d = job_done_i ? fdtd_pkg::PH_IDLE : fdtd_pkg::PH_READ;
            end
            default:
            begin
                phase_d = fdtd_pkg::PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
            phase_q <= fdtd_pkg::PH_IDLE;
        else
            phase_q <= phase_d;
    end

    assign phase_o = phase_q;
    assign load_o  = (phase_q == fdtd_pkg::PH_IDLE) && start_i;
    assign busy_o  = (phase_q != fdtd_pkg::PH_IDLE);

    //////////////////////////////////////////////////////////////////////
    // interrupt
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
            busy_q <= 1'b0;
        else
            busy_q <= busy_o;
    end

    // set on the falling edge of busy, clear wins
    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
            int_pending_o <= 1'b0;
        else if (clr_int_i)
            int_pending_o <= 1'b0;
        else if (busy_q && !busy_o)
            int_pending_o <= 1'b1;
    end

    assign int_o = int_pending_o && int_en_i;

endmodule

// File: hw/fdtd_pkg.sv
`include "fdtd_defs.svh"

package fdtd_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int SIZE_W      = 16;

    // words per field held by the compute buffer
    localparam int BLOCK_WORDS = 8;

    // block counters run across Hy then Ez, so up to twice the block
    localparam int BLK_CNT_W   = `FDTD_CNT_W(2 * BLOCK_WORDS);
    localparam logic [SIZE_W-1:0] BLOCK_LEN = SIZE_W'(BLOCK_WORDS);

    typedef enum logic {FLD_HY, FLD_EZ} field_e;

    typedef enum logic [1:0] {PH_IDLE, PH_READ, PH_WRITE} phase_e;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } mem_wr_t;

    typedef struct packed {
        logic              valid;
        field_e            field;
        logic [DATA_W-1:0] data;
    } fld_word_t;

    typedef struct packed {
        logic [ADDR_W-1:0] hy_base;
        logic [ADDR_W-1:0] ez_base;
        logic [SIZE_W-1:0] size;
    } job_cfg_t;

endpackage

// File: include/fdtd_defs.svh
`ifndef FDTD_DEFS_SVH
`define FDTD_DEFS_SVH

// bits needed to hold the value n itself
`define FDTD_CNT_W(n) ($clog2((n) + 1))

`endif
